// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module core_tb -f sources.f -o core_sim
out=$(./obj_dir/core_sim || true)
echo "$out"
echo "$out" | grep -Fqx '>>> PASS'

// File: sources.f
src/core_pkg.sv
src/stage_reg.sv
src/regfile.sv
src/decode.sv
src/fwdmux.sv
src/execute.sv
src/memory.sv
src/core.sv
test/core_tb.sv

// File: src/core.sv
`timescale 1ns/1ps

module core (
	input logic clk,
	input logic reset,
	output core_pkg::ibus_req_t ireq,
	input core_pkg::ibus_resp_t iresp,
	output core_pkg::dbus_req_t dreq,
	input core_pkg::dbus_resp_t dresp,
	input logic trint,
	input logic swint,
	input logic exint,
	output core_pkg::commit_t commit
);

	// trint, swint and exint are not serviced.
	core_pkg::addr_t pc;
	logic stall_fetch;
	logic stall_mem;
	logic advance;

	core_pkg::fetch_data_t dataF_nxt;
	core_pkg::fetch_data_t dataF;
	core_pkg::decode_data_t dataD_nxt;
	core_pkg::decode_data_t dataD;
	core_pkg::execute_data_t dataE_nxt;
	core_pkg::execute_data_t dataE;
	core_pkg::memory_data_t dataM_nxt;
	core_pkg::memory_data_t dataM;
	core_pkg::memory_data_t dataW;
	logic validF, validD, validE, validM, validW;
	core_pkg::word_t srca;
	core_pkg::word_t srcb;

	assign ireq.valid = 1'b1;
	assign ireq.addr = pc;
	assign stall_fetch = ireq.valid & ~iresp.data_ok;
	assign stall_mem = dreq.valid & ~dresp.data_ok;
	assign advance = ~stall_mem;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= core_pkg::reset_pc;
		end else if (!stall_fetch && !stall_mem) begin
			pc <= pc + 64'd4;
		end
	end

	// no data_ok means a bubble enters fetch.
	assign dataF_nxt = '{pc: pc, raw_instr: iresp.data};

	stage_reg #(.payload_t(core_pkg::fetch_data_t)) reg_f (
		.clk, .reset, .advance, .bubble(1'b0),
		.d(dataF_nxt), .valid_in(iresp.data_ok), .q(dataF), .valid_out(validF)
	);

	// writeback happens from the memory stage register.
	decode u_decode (
		.clk, .reset, .dataF, .dataD(dataD_nxt),
		.wen(validM & dataM.regwrite), .wa(dataM.dst), .wd(dataM.writedata)
	);

	stage_reg #(.payload_t(core_pkg::decode_data_t)) reg_d (
		.clk, .reset, .advance, .bubble(1'b0),
		.d(dataD_nxt), .valid_in(validF), .q(dataD), .valid_out(validD)
	);

	fwdmux u_fwdmux (
		.dataD, .validE, .validM, .dataE, .dataM, .srca, .srcb
	);

	execute u_execute (
		.dataD, .srca, .srcb, .dataE(dataE_nxt)
	);

	stage_reg #(.payload_t(core_pkg::execute_data_t)) reg_e (
		.clk, .reset, .advance, .bubble(1'b0),
		.d(dataE_nxt), .valid_in(validD), .q(dataE), .valid_out(validE)
	);

	memory u_memory (
		.clk, .reset, .dataE, .validE, .dreq, .dresp, .dataM(dataM_nxt)
	);

	stage_reg #(.payload_t(core_pkg::memory_data_t)) reg_m (
		.clk, .reset, .advance, .bubble(1'b0),
		.d(dataM_nxt), .valid_in(validE), .q(dataM), .valid_out(validM)
	);

	// a held memory stage must not retire twice.
	stage_reg #(.payload_t(core_pkg::memory_data_t)) reg_w (
		.clk, .reset, .advance, .bubble(stall_mem),
		.d(dataM), .valid_in(validM), .q(dataW), .valid_out(validW)
	);

	assign commit = '{valid: validW, pc: dataW.pc, instr: dataW.raw_instr,
		wen: dataW.regwrite, wdest: dataW.dst, wdata: dataW.writedata};

	pc_hold: assert property (@(posedge clk) disable iff (reset)
		(stall_fetch || stall_mem) |=> $stable(pc));

endmodule

// File: src/core_pkg.sv
package core_pkg;

	typedef logic [63:0] word_t;
	typedef logic [63:0] addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] creg_addr_t;

	localparam addr_t reset_pc = 64'h8000_0000;

	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	// funct3 of ld and sd.
	localparam logic [2:0] f3_dword = 3'b011;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor
	} alu_op_t;

	typedef struct packed {
		logic valid;
		addr_t addr;
	} ibus_req_t;

	typedef struct packed {
		logic data_ok;
		instr_t data;
	} ibus_resp_t;

	typedef struct packed {
		logic valid;
		logic write;
		addr_t addr;
		word_t wdata;
	} dbus_req_t;

	typedef struct packed {
		logic data_ok;
		word_t data;
	} dbus_resp_t;

	typedef struct packed {
		logic regwrite;
		logic memread;
		logic memwrite;
		alu_op_t alu_op;
		logic use_imm;
	} ctl_t;

	typedef struct packed {
		addr_t pc;
		instr_t raw_instr;
	} fetch_data_t;

	typedef struct packed {
		addr_t pc;
		instr_t raw_instr;
		ctl_t ctl;
		creg_addr_t ra1;
		creg_addr_t ra2;
		creg_addr_t dst;
		word_t srca;
		word_t srcb;
		word_t imm;
	} decode_data_t;

	typedef struct packed {
		addr_t pc;
		instr_t raw_instr;
		ctl_t ctl;
		creg_addr_t dst;
		word_t result;
		word_t storedata;
	} execute_data_t;

	typedef struct packed {
		addr_t pc;
		instr_t raw_instr;
		logic regwrite;
		creg_addr_t dst;
		word_t writedata;
	} memory_data_t;

	typedef struct packed {
		logic valid;
		addr_t pc;
		instr_t instr;
		logic wen;
		creg_addr_t wdest;
		word_t wdata;
	} commit_t;

endpackage

// File: src/decode.sv
`timescale 1ns/1ps

module decode (
	input logic clk,
	input logic reset,
	input core_pkg::fetch_data_t dataF,
	output core_pkg::decode_data_t dataD,
	input logic wen,
	input core_pkg::creg_addr_t wa,
	input core_pkg::word_t wd
);

	core_pkg::instr_t instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	core_pkg::creg_addr_t ra1;
	core_pkg::creg_addr_t ra2;
	core_pkg::word_t imm_i;
	core_pkg::word_t imm_s;
	core_pkg::word_t rd1;
	core_pkg::word_t rd2;
	core_pkg::ctl_t ctl;

	assign instr = dataF.raw_instr;
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign ra1 = instr[19:15];
	assign ra2 = instr[24:20];
	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};

	// anything not listed stays a nop with no write and no memory access.
	always_comb begin
		ctl = '0;
		case (opcode)
			core_pkg::op_imm: begin
				ctl.regwrite = (funct3 == 3'b000);
				ctl.use_imm = 1'b1;
			end
			core_pkg::op_reg: begin
				ctl.regwrite = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: ctl.alu_op = core_pkg::alu_add;
					10'b0100000_000: ctl.alu_op = core_pkg::alu_sub;
					10'b0000000_111: ctl.alu_op = core_pkg::alu_and;
					10'b0000000_110: ctl.alu_op = core_pkg::alu_or;
					10'b0000000_100: ctl.alu_op = core_pkg::alu_xor;
					default: ctl.regwrite = 1'b0;
				endcase
			end
			core_pkg::op_load: begin
				ctl.regwrite = (funct3 == core_pkg::f3_dword);
				ctl.memread = (funct3 == core_pkg::f3_dword);
				ctl.use_imm = 1'b1;
			end
			core_pkg::op_store: begin
				ctl.memwrite = (funct3 == core_pkg::f3_dword);
				ctl.use_imm = 1'b1;
			end
			default: ;
		endcase
	end

	regfile u_regfile (
		.clk,
		.reset,
		.ra1,
		.ra2,
		.rd1,
		.rd2,
		.wen,
		.wa,
		.wd
	);

	assign dataD = '{pc: dataF.pc, raw_instr: instr, ctl: ctl, ra1: ra1, ra2: ra2,
		dst: instr[11:7], srca: rd1, srcb: rd2,
		imm: (opcode == core_pkg::op_store) ? imm_s : imm_i};

endmodule

// File: src/execute.sv
`timescale 1ns/1ps

module execute (
	input core_pkg::decode_data_t dataD,
	input core_pkg::word_t srca,
	input core_pkg::word_t srcb,
	output core_pkg::execute_data_t dataE
);

	core_pkg::word_t opb;
	core_pkg::word_t alu_out;

	assign opb = dataD.ctl.use_imm ? dataD.imm : srcb;

	// loads and stores use alu_add, so the result is the address.
	always_comb begin
		case (dataD.ctl.alu_op)
			core_pkg::alu_sub: alu_out = srca - opb;
			core_pkg::alu_and: alu_out = srca & opb;
			core_pkg::alu_or: alu_out = srca | opb;
			core_pkg::alu_xor: alu_out = srca ^ opb;
			default: alu_out = srca + opb;
		endcase
	end

	assign dataE = '{pc: dataD.pc, raw_instr: dataD.raw_instr, ctl: dataD.ctl,
		dst: dataD.dst, result: alu_out, storedata: srcb};

endmodule

// File: src/fwdmux.sv
`timescale 1ns/1ps

module fwdmux (
	input core_pkg::decode_data_t dataD,
	input logic validE,
	input logic validM,
	input core_pkg::execute_data_t dataE,
	input core_pkg::memory_data_t dataM,
	output core_pkg::word_t srca,
	output core_pkg::word_t srcb
);

	logic e_wr;
	logic m_wr;

	assign e_wr = validE & dataE.ctl.regwrite;
	assign m_wr = validM & dataM.regwrite;

	// execute holds the younger producer, so it is checked first.
	function automatic core_pkg::word_t fwd(input core_pkg::creg_addr_t ra,
		input core_pkg::word_t rf_val);
		if (ra == '0)
			return rf_val;
		if (e_wr && dataE.dst == ra)
			return dataE.result;
		if (m_wr && dataM.dst == ra)
			return dataM.writedata;
		return rf_val;
	endfunction

	always_comb begin
		srca = fwd(dataD.ra1, dataD.srca);
		srcb = fwd(dataD.ra2, dataD.srcb);
	end

endmodule

// File: src/memory.sv
`timescale 1ns/1ps

module memory (
	input logic clk,
	input logic reset,
	input core_pkg::execute_data_t dataE,
	input logic validE,
	output core_pkg::dbus_req_t dreq,
	input core_pkg::dbus_resp_t dresp,
	output core_pkg::memory_data_t dataM
);

	// the request stays up until data_ok, since the execute register holds.
	assign dreq.valid = validE & (dataE.ctl.memread | dataE.ctl.memwrite);
	assign dreq.write = dataE.ctl.memwrite;
	assign dreq.addr = dataE.result;
	assign dreq.wdata = dataE.storedata;

	// load data is taken in the data_ok cycle.
	assign dataM = '{pc: dataE.pc, raw_instr: dataE.raw_instr,
		regwrite: dataE.ctl.regwrite, dst: dataE.dst,
		writedata: dataE.ctl.memread ? dresp.data : dataE.result};

	dreq_stable: assert property (@(posedge clk) disable iff (reset)
		dreq.valid && !dresp.data_ok |=> $stable(dreq));

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic reset,
	input core_pkg::creg_addr_t ra1,
	input core_pkg::creg_addr_t ra2,
	output core_pkg::word_t rd1,
	output core_pkg::word_t rd2,
	input logic wen,
	input core_pkg::creg_addr_t wa,
	input core_pkg::word_t wd
);

	core_pkg::word_t regs [31:1];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// write-before-read bypass.
	assign rd1 = (ra1 == '0) ? '0 : (wen && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (wen && wa == ra2) ? wd : regs[ra2];

	for (genvar i = 1; i < 32; i++) begin : g_hold
		reg_hold: assert property (@(posedge clk) disable iff (reset)
			!(wen && wa == 5'(i)) |=> $stable(regs[i]));
	end

endmodule

// File: src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic advance,
	input logic bubble,
	input payload_t d,
	input logic valid_in,
	output payload_t q,
	output logic valid_out
);

	// advance wins over bubble, otherwise the stage holds.
	always_ff @(posedge clk) begin
		if (reset) begin
			q <= '0;
			valid_out <= 1'b0;
		end else if (advance) begin
			q <= d;
			valid_out <= valid_in;
		end else if (bubble) begin
			valid_out <= 1'b0;
		end
	end

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int n_entries = 24;
	localparam int wd_limit = (n_entries * 40 + 5) * 100;

	typedef struct packed {
		core_pkg::instr_t instr;
		logic wen;
		core_pkg::creg_addr_t wdest;
		core_pkg::word_t wdata;
		logic store;
		core_pkg::addr_t saddr;
	} entry_t;

	logic clk;
	logic reset;
	core_pkg::ibus_req_t ireq;
	core_pkg::ibus_resp_t iresp;
	core_pkg::dbus_req_t dreq;
	core_pkg::dbus_resp_t dresp;
	core_pkg::commit_t commit;

	entry_t prog_tab [n_entries];
	core_pkg::dbus_req_t exp_st [$];
	core_pkg::word_t dmem [16];
	int iwait;
	int dwait;
	int done_n;

	core dut0 (
		.clk, .reset, .ireq, .iresp, .dreq, .dresp,
		.trint(1'b0), .swint(1'b0), .exint(1'b0), .commit
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic core_pkg::instr_t enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1,
		int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic core_pkg::instr_t enc_r(logic [6:0] f7, logic [2:0] f3, int rd, int rs1,
		int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), core_pkg::op_reg};
	endfunction

	function automatic core_pkg::instr_t enc_sd(int rs2, int rs1, int imm);
		logic [11:0] im;
		im = 12'(imm);
		return {im[11:5], 5'(rs2), 5'(rs1), core_pkg::f3_dword, im[4:0], core_pkg::op_store};
	endfunction

	function automatic entry_t wr(core_pkg::instr_t instr, int rd, core_pkg::word_t v);
		return '{instr: instr, wen: 1'b1, wdest: 5'(rd), wdata: v, store: 1'b0, saddr: '0};
	endfunction

	function automatic entry_t st(core_pkg::instr_t instr, core_pkg::addr_t a, core_pkg::word_t v);
		return '{instr: instr, wen: 1'b0, wdest: '0, wdata: v, store: 1'b1, saddr: a};
	endfunction

	function automatic core_pkg::instr_t fetch_word(core_pkg::addr_t addr);
		core_pkg::addr_t idx;
		idx = (addr - core_pkg::reset_pc) >> 2;
		if (idx < 64'(n_entries))
			return prog_tab[idx[4:0]].instr;
		return 32'h0000_0013;
	endfunction

	task automatic abort_run(input string line);
		$display("%s", line);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_commit(input core_pkg::commit_t got, input core_pkg::commit_t exp);
		string msg;
		if (got.pc !== exp.pc || got.instr !== exp.instr || got.wen !== exp.wen
			|| (exp.wen && (got.wdest !== exp.wdest || got.wdata !== exp.wdata))) begin
			msg = $sformatf("[FAIL] %0d ns: commit pc %h instr %h wen %b x%0d=%h",
				$time, got.pc, got.instr, got.wen, got.wdest, got.wdata);
			msg = {msg, $sformatf(", expected pc %h instr %h wen %b x%0d=%h",
				exp.pc, exp.instr, exp.wen, exp.wdest, exp.wdata)};
			abort_run(msg);
		end
	endtask

	task automatic check_store(input core_pkg::dbus_req_t got);
		core_pkg::dbus_req_t exp;
		if (exp_st.size() == 0) begin
			abort_run($sformatf("a store to %h came that the program does not hold", got.addr));
		end else begin
			exp = exp_st.pop_front();
			if (got.addr !== exp.addr || got.wdata !== exp.wdata)
				abort_run($sformatf("[FAIL] %0d ns: store %h to %h, expected %h to %h",
					$time, got.wdata, got.addr, exp.wdata, exp.addr));
		end
	endtask

	// instruction bus, one data_ok pulse per answer.
	always @(posedge clk) begin
		core_pkg::addr_t next_addr;
		// an answer is taken unless a data access is waiting, and then pc moves on.
		next_addr = ireq.addr;
		if (iresp.data_ok && !(dreq.valid && !dresp.data_ok))
			next_addr = ireq.addr + 64'd4;
		iresp.data_ok <= 1'b0;
		if (!reset && ireq.valid) begin
			if (iwait == 0) begin
				iresp.data_ok <= 1'b1;
				iresp.data <= fetch_word(next_addr);
				iwait <= ($urandom % 2 == 0) ? 0 : $urandom % 4;
			end else begin
				iwait <= iwait - 1;
			end
		end
	end

	always @(posedge clk) begin
		dresp.data_ok <= 1'b0;
		if (!reset && dreq.valid && !dresp.data_ok) begin
			if (dwait == 0) begin
				dresp.data_ok <= 1'b1;
				dresp.data <= dmem[dreq.addr[6:3]];
				if (dreq.write) begin
					dmem[dreq.addr[6:3]] <= dreq.wdata;
					check_store(dreq);
				end
				// now and then a long wait.
				dwait <= ($urandom % 5 == 0) ? 6 : $urandom % 4;
			end else begin
				dwait <= dwait - 1;
			end
		end
	end

	initial begin
		#(wd_limit);
		abort_run($sformatf("timeout: retirement stalled after %0d of %0d commits",
			done_n, n_entries));
	end

	initial begin
		core_pkg::commit_t exp;
		void'($urandom(32'hd4782a2d));
		reset <= 1'b1;
		iresp <= '0;
		dresp <= '0;
		for (int i = 0; i < 16; i++) begin
			dmem[i] <= 64'h5a5a_0000_0000_0000 | 64'(i * 8);
		end
		prog_tab[0] = wr(enc_i(core_pkg::op_imm, 3'd0, 1, 0, 5), 1, 64'd5);
		prog_tab[1] = wr(enc_i(core_pkg::op_imm, 3'd0, 2, 1, -3), 2, 64'd2);
		prog_tab[2] = wr(enc_r(7'h00, 3'd0, 3, 1, 2), 3, 64'd7);
		prog_tab[3] = wr(enc_r(7'h20, 3'd0, 4, 2, 3), 4, 64'hffff_ffff_ffff_fffb);
		prog_tab[4] = wr(enc_r(7'h00, 3'd7, 5, 4, 3), 5, 64'd3);
		prog_tab[5] = wr(enc_r(7'h00, 3'd6, 6, 4, 1), 6, 64'hffff_ffff_ffff_ffff);
		prog_tab[6] = wr(enc_r(7'h00, 3'd4, 7, 6, 3), 7, 64'hffff_ffff_ffff_fff8);
		// x0 takes the write on the commit port only.
		prog_tab[7] = wr(enc_i(core_pkg::op_imm, 3'd0, 0, 1, 9), 0, 64'd14);
		prog_tab[8] = wr(enc_r(7'h00, 3'd0, 8, 0, 1), 8, 64'd5);
		prog_tab[9] = wr(enc_i(core_pkg::op_imm, 3'd0, 9, 0, 64), 9, 64'h40);
		prog_tab[10] = st(enc_sd(7, 9, 8), 64'h48, 64'hffff_ffff_ffff_fff8);
		prog_tab[11] = st(enc_sd(4, 9, 0), 64'h40, 64'hffff_ffff_ffff_fffb);
		prog_tab[12] = wr(enc_i(core_pkg::op_imm, 3'd0, 10, 0, 1), 10, 64'd1);
		prog_tab[13] = wr(enc_i(core_pkg::op_load, 3'd3, 11, 9, 8), 11, 64'hffff_ffff_ffff_fff8);
		prog_tab[14] = wr(enc_i(core_pkg::op_imm, 3'd0, 12, 0, 2047), 12, 64'h7ff);
		prog_tab[15] = wr(enc_i(core_pkg::op_load, 3'd3, 13, 9, 0), 13, 64'hffff_ffff_ffff_fffb);
		prog_tab[16] = wr(enc_r(7'h00, 3'd0, 14, 11, 12), 14, 64'h7f7);
		prog_tab[17] = '{instr: 32'hffff_ffff, default: '0};
		prog_tab[18] = wr(enc_r(7'h00, 3'd4, 15, 13, 0), 15, 64'hffff_ffff_ffff_fffb);
		prog_tab[19] = wr(enc_r(7'h20, 3'd0, 16, 0, 10), 16, 64'hffff_ffff_ffff_ffff);
		prog_tab[20] = wr(enc_r(7'h00, 3'd7, 17, 16, 12), 17, 64'h7ff);
		prog_tab[21] = wr(enc_r(7'h00, 3'd0, 18, 0, 0), 18, 64'd0);
		prog_tab[22] = wr(32'h0000_0013, 0, 64'd0);
		prog_tab[23] = wr(32'h0000_0013, 0, 64'd0);
		for (int i = 0; i < n_entries; i++) begin
			if (prog_tab[i].store)
				exp_st.push_back('{valid: 1'b1, write: 1'b1, addr: prog_tab[i].saddr,
					wdata: prog_tab[i].wdata});
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			do @(posedge clk); while (!commit.valid);
			exp = '{valid: 1'b1, pc: core_pkg::reset_pc + 64'(i * 4), instr: prog_tab[i].instr,
				wen: prog_tab[i].wen, wdest: prog_tab[i].wdest, wdata: prog_tab[i].wdata};
			check_commit(commit, exp);
			done_n = i + 1;
		end
		if (exp_st.size() != 0) begin
			abort_run($sformatf("%0d stores never reached the data bus", exp_st.size()));
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule
